//--- common/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  // Byte lanes in one data word
  localparam int BYTE_LANES = 4;

  // Data and address word
  typedef logic [31:0] word_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Load/store size and sign field
  // Low two bits give the size, bit 2 marks unsigned
  typedef logic [2:0] funct3_t;

  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // One enable bit per byte lane
  typedef logic [BYTE_LANES-1:0] strb_t;

  // Which value the instruction writes back
  typedef logic [1:0] res_src_t;

  localparam res_src_t RES_ALU = 2'd0;
  localparam res_src_t RES_MEM = 2'd1;
  localparam res_src_t RES_PC4 = 2'd2;
  localparam res_src_t RES_TGT = 2'd3;

  // Trap cause carried down the pipe
  typedef logic [1:0] trap_code_t;

  localparam trap_code_t TRAP_NONE           = 2'd0;
  localparam trap_code_t TRAP_ILLEGAL        = 2'd1;
  localparam trap_code_t TRAP_FETCH_MISALIGN = 2'd2;
  localparam trap_code_t TRAP_LDST_MISALIGN  = 2'd3;

endpackage

`default_nettype wire

//--- design/store_align.sv
`default_nettype none

module store_align (
  input  mem_stage_pkg::word_t   wdata_in,
  input  logic [1:0]             byte_off,
  input  mem_stage_pkg::funct3_t funct3,
  input  logic                   store_en,
  output mem_stage_pkg::word_t   wdata,
  output mem_stage_pkg::strb_t   wstrb
);

  import mem_stage_pkg::*;

  // Stores ignore the sign bit and need only the size
  logic [1:0] size;
  strb_t      strb_raw;

  assign size = funct3[1:0];

  // Data is replicated so that every lane holds the value,
  // the strobe then picks the lane(s) that really get written
  always_comb begin
    wdata    = wdata_in;
    strb_raw = '1;
    case (size)
      F3_B[1:0]: begin
        wdata    = {BYTE_LANES{wdata_in[7:0]}};
        // One-hot lane at the byte offset
        strb_raw = strb_t'(4'b0001 << byte_off);
      end
      F3_H[1:0]: begin
        wdata    = {(BYTE_LANES / 2){wdata_in[15:0]}};
        // Offset bit 1 picks the upper or lower half
        strb_raw = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // Full word writes every lane
        wdata    = wdata_in;
        strb_raw = '1;
      end
    endcase
  end

  // No lanes when there is no store
  assign wstrb = store_en ? strb_raw : '0;

endmodule

`default_nettype wire

//--- design/load_extend.sv
`default_nettype none

module load_extend (
  input  mem_stage_pkg::word_t   rdata,
  input  logic [1:0]             byte_off,
  input  mem_stage_pkg::funct3_t funct3,
  output mem_stage_pkg::word_t   ld_data
);

  import mem_stage_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Byte at the offset within the read word
  assign sel_byte = rdata[{byte_off, 3'b000} +: 8];

  // Halfword chosen by offset bit 1
  assign sel_half = byte_off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      // Signed forms copy the field's top bit upward
      F3_B: begin
        ld_data = {{24{sel_byte[7]}}, sel_byte};
      end
      F3_H: begin
        ld_data = {{16{sel_half[15]}}, sel_half};
      end
      // Unsigned forms fill with zeros
      F3_BU: begin
        ld_data = {24'h000000, sel_byte};
      end
      F3_HU: begin
        ld_data = {16'h0000, sel_half};
      end
      default: begin
        // Word load needs no extension
        ld_data = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/ldst_misalign_check.sv
`default_nettype none

module ldst_misalign_check (
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  mem_stage_pkg::funct3_t funct3,
  input  logic [1:0]             byte_off,
  input  logic                   trap_in,
  output logic                   misalign,
  output logic                   trap_any,
  output logic                   ren,
  output logic                   we
);

  import mem_stage_pkg::*;

  logic access;

  assign access = mem_read | mem_write;

  // Halfword needs even address, word needs offset 0
  // Byte accesses can never be misaligned
  always_comb begin
    misalign = 1'b0;
    if (access) begin
      case (funct3[1:0])
        F3_H[1:0]: misalign = byte_off[0];
        F3_W[1:0]: misalign = |byte_off;
        default:   misalign = 1'b0;
      endcase
    end
  end

  // Either an earlier stage's trap or our own
  assign trap_any = trap_in | misalign;

  // Memory is never touched by a trapping instruction
  assign ren = mem_read & ~trap_any;
  assign we  = mem_write & ~trap_any;

  // Misalignment decoded again from the raw request
  always_comb begin
    if (access && ((funct3[1:0] == 2'b01 && byte_off[0]) ||
                   (funct3[1:0] == 2'b10 && byte_off != 2'b00))) begin
      a_no_misaligned_access: assert final (!ren && !we);
    end
  end

endmodule

`default_nettype wire

//--- design/mem_wb_reg.sv
`default_nettype none

module mem_wb_reg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  input  logic                      m_ready,
  input  logic                      reg_write_in,
  input  logic                      misalign,
  input  logic                      trap_any,
  input  mem_stage_pkg::res_src_t   res_src_in,
  input  mem_stage_pkg::reg_idx_t   rd_in,
  input  mem_stage_pkg::word_t      alu_result_in,
  input  mem_stage_pkg::word_t      ld_data_in,
  input  mem_stage_pkg::word_t      pc_plus4_in,
  input  mem_stage_pkg::word_t      jb_target_in,
  input  mem_stage_pkg::trap_code_t trap_code_in,
  output logic                      m_valid,
  output logic                      reg_write_wb,
  output mem_stage_pkg::res_src_t   res_src_wb,
  output mem_stage_pkg::reg_idx_t   rd_wb,
  output mem_stage_pkg::word_t      alu_result_wb,
  output mem_stage_pkg::word_t      ld_data_wb,
  output mem_stage_pkg::word_t      pc_plus4_wb,
  output mem_stage_pkg::word_t      jb_target_wb,
  output logic                      trap_wb,
  output mem_stage_pkg::trap_code_t trap_code_wb
);

  import mem_stage_pkg::*;

  // Register is free when empty or being drained this cycle
  logic load_en;

  assign load_en = !m_valid || m_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (load_en) begin
      m_valid <= s_valid;
    end
  end

  // Payload follows the same enable as m_valid
  always_ff @(posedge clk) begin
    if (load_en) begin
      // A trapping instruction must not write the register file
      reg_write_wb  <= reg_write_in && !trap_any;
      res_src_wb    <= res_src_in;
      rd_wb         <= rd_in;
      alu_result_wb <= alu_result_in;
      ld_data_wb    <= ld_data_in;
      pc_plus4_wb   <= pc_plus4_in;
      jb_target_wb  <= jb_target_in;
      trap_wb       <= trap_any;
      // Own misalign overrides whatever code came from upstream
      trap_code_wb  <= misalign ? TRAP_LDST_MISALIGN : trap_code_in;
    end
  end

  // Offered item stays offered until writeback takes it
  a_valid_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid
  );

  // Nothing on the writeback side moves during a stall
  a_payload_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> $stable({reg_write_wb, res_src_wb, rd_wb, alu_result_wb,
                                     ld_data_wb, pc_plus4_wb, jb_target_wb,
                                     trap_wb, trap_code_wb})
  );

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none

module mem_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  logic                      reg_write_mem,
  input  logic                      mem_read_mem,
  input  logic                      mem_write_mem,
  input  mem_stage_pkg::res_src_t   res_src_mem,
  input  mem_stage_pkg::reg_idx_t   rd_mem,
  input  mem_stage_pkg::funct3_t    funct3_mem,
  input  mem_stage_pkg::word_t      alu_result_mem,
  input  mem_stage_pkg::word_t      rs2_data_mem,
  input  mem_stage_pkg::word_t      pc_plus4_mem,
  input  mem_stage_pkg::word_t      jb_target_mem,
  input  logic                      trap_mem,
  input  mem_stage_pkg::trap_code_t trap_code_mem,
  output logic                      dmem_ren,
  output mem_stage_pkg::word_t      dmem_raddr,
  input  mem_stage_pkg::word_t      dmem_rdata,
  output logic                      dmem_we,
  output mem_stage_pkg::word_t      dmem_waddr,
  output mem_stage_pkg::word_t      dmem_wdata,
  output mem_stage_pkg::strb_t      dmem_wstrb,
  output logic                      m_valid,
  input  logic                      m_ready,
  output logic                      reg_write_wb,
  output mem_stage_pkg::res_src_t   res_src_wb,
  output mem_stage_pkg::reg_idx_t   rd_wb,
  output mem_stage_pkg::word_t      alu_result_wb,
  output mem_stage_pkg::word_t      ld_data_wb,
  output mem_stage_pkg::word_t      pc_plus4_wb,
  output mem_stage_pkg::word_t      jb_target_wb,
  output logic                      trap_wb,
  output mem_stage_pkg::trap_code_t trap_code_wb,
  output mem_stage_pkg::word_t      result_mem,
  output mem_stage_pkg::word_t      load_data_mem
);

  import mem_stage_pkg::*;

  logic [1:0] byte_off;
  logic       misalign;
  logic       trap_any;
  word_t      ld_data_ext;

  // Lane offset inside the addressed word
  assign byte_off = alu_result_mem[1:0];

  // Nothing buffers here, so upstream stalls exactly with writeback
  assign s_ready = m_ready;

  // Memory is word addressed and lanes come from strobe or extend
  assign dmem_raddr = {alu_result_mem[31:2], 2'b00};
  assign dmem_waddr = {alu_result_mem[31:2], 2'b00};

  // Alignment check also gates the memory enables
  ldst_misalign_check u_misalign (
    .mem_read  (mem_read_mem),
    .mem_write (mem_write_mem),
    .funct3    (funct3_mem),
    .byte_off  (byte_off),
    .trap_in   (trap_mem),
    .misalign  (misalign),
    .trap_any  (trap_any),
    .ren       (dmem_ren),
    .we        (dmem_we)
  );

  // Stores take forwarded rs2 from execute
  store_align u_store (
    .wdata_in (rs2_data_mem),
    .byte_off (byte_off),
    .funct3   (funct3_mem),
    .store_en (mem_write_mem),
    .wdata    (dmem_wdata),
    .wstrb    (dmem_wstrb)
  );

  // SRAM data arrives this cycle, so formatting happens here
  load_extend u_load (
    .rdata    (dmem_rdata),
    .byte_off (byte_off),
    .funct3   (funct3_mem),
    .ld_data  (ld_data_ext)
  );

  // Forwarded value for the instruction now in this stage
  always_comb begin
    case (res_src_mem)
      RES_MEM: result_mem = ld_data_ext;
      RES_PC4: result_mem = pc_plus4_mem;
      RES_TGT: result_mem = jb_target_mem;
      default: result_mem = alu_result_mem;
    endcase
  end

  assign load_data_mem = ld_data_ext;

  mem_wb_reg u_wb_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_valid       (s_valid),
    .m_ready       (m_ready),
    .reg_write_in  (reg_write_mem),
    .misalign      (misalign),
    .trap_any      (trap_any),
    .res_src_in    (res_src_mem),
    .rd_in         (rd_mem),
    .alu_result_in (alu_result_mem),
    .ld_data_in    (ld_data_ext),
    .pc_plus4_in   (pc_plus4_mem),
    .jb_target_in  (jb_target_mem),
    .trap_code_in  (trap_code_mem),
    .m_valid       (m_valid),
    .reg_write_wb  (reg_write_wb),
    .res_src_wb    (res_src_wb),
    .rd_wb         (rd_wb),
    .alu_result_wb (alu_result_wb),
    .ld_data_wb    (ld_data_wb),
    .pc_plus4_wb   (pc_plus4_wb),
    .jb_target_wb  (jb_target_wb),
    .trap_wb       (trap_wb),
    .trap_code_wb  (trap_code_wb)
  );

endmodule

`default_nettype wire

//--- bench/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;

  import mem_stage_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DLY      = 5;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_TESTS      = 4;
  localparam int ITEMS_PER_TEST = 150;
  localparam int MAX_CYCLES     = 40 * NUM_TESTS * ITEMS_PER_TEST + RESET_CYCLES;
  localparam int ITEM_W         = 139;

  logic       clk;
  logic       rst_n;
  logic       s_valid;
  logic       s_ready;
  logic       reg_write_mem;
  logic       mem_read_mem;
  logic       mem_write_mem;
  res_src_t   res_src_mem;
  reg_idx_t   rd_mem;
  funct3_t    funct3_mem;
  word_t      alu_result_mem;
  word_t      rs2_data_mem;
  word_t      pc_plus4_mem;
  word_t      jb_target_mem;
  logic       trap_mem;
  trap_code_t trap_code_mem;
  logic       dmem_ren;
  word_t      dmem_raddr;
  word_t      dmem_rdata;
  logic       dmem_we;
  word_t      dmem_waddr;
  word_t      dmem_wdata;
  strb_t      dmem_wstrb;
  logic       m_valid;
  logic       m_ready;
  logic       reg_write_wb;
  res_src_t   res_src_wb;
  reg_idx_t   rd_wb;
  word_t      alu_result_wb;
  word_t      ld_data_wb;
  word_t      pc_plus4_wb;
  word_t      jb_target_wb;
  logic       trap_wb;
  trap_code_t trap_code_wb;
  word_t      result_mem;
  word_t      load_data_mem;

  mem_stage u_dut (.*);

  // Data memory and its expected image
  word_t mem [64];
  word_t shadow [64];

  // Scoreboard state
  logic [ITEM_W-1:0] exp_q [$];
  logic [ITEM_W-1:0] head_item;
  logic [ITEM_W-1:0] wb_item;
  int                q_count;
  logic              seen_xfer = 1'b0;
  int                errors = 0;
  int                cycles = 0;
  int                total_items = 0;

  funct3_t f3_codes [5] = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
  string   test_names [NUM_TESTS] = '{"stores", "loads", "misaligned", "mixed"};

  // Expected values for the item now in the stage
  logic [1:0] cur_off;
  logic [5:0] cur_idx;
  logic       cur_mis;
  logic       cur_trap;
  trap_code_t cur_code;
  word_t      cur_word_addr;
  word_t      cur_shadow;
  word_t      cur_ld;
  word_t      cur_wdata;
  strb_t      cur_strb;
  logic       exp_ren;
  logic       exp_we;
  word_t      exp_res;

  // Lane i is written when it lies inside the accessed field
  function automatic strb_t lane_strb(input funct3_t f3, input logic [1:0] off);
    strb_t      s;
    logic [1:0] lane;
    for (int i = 0; i < BYTE_LANES; i++) begin
      lane = 2'(i);
      case (f3[1:0])
        2'b00:   s[i] = (lane == off);
        2'b01:   s[i] = (lane[1] == off[1]);
        default: s[i] = 1'b1;
      endcase
    end
    return s;
  endfunction

  // Store data copied into every lane of its size
  function automatic word_t store_word(input word_t d, input funct3_t f3);
    case (f3[1:0])
      2'b00:   return {4{d[7:0]}};
      2'b01:   return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  // Shift the field down to bit 0, then extend by sign or zero
  function automatic word_t ext_load(input word_t w, input logic [1:0] off, input funct3_t f3);
    word_t b_f;
    word_t h_f;
    b_f = w >> (8 * off);
    h_f = w >> (16 * off[1]);
    case (f3)
      F3_B:    return 32'($signed(b_f[7:0]));
      F3_H:    return 32'($signed(h_f[15:0]));
      F3_BU:   return {24'h000000, b_f[7:0]};
      F3_HU:   return {16'h0000, h_f[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic misaligned(input funct3_t f3, input logic [1:0] off);
    return (f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00);
  endfunction

  assign cur_off       = alu_result_mem[1:0];
  assign cur_idx       = alu_result_mem[7:2];
  assign cur_word_addr = alu_result_mem & ~32'h3;
  assign cur_mis       = (mem_read_mem | mem_write_mem) && misaligned(funct3_mem, cur_off);
  assign cur_trap      = trap_mem | cur_mis;
  assign cur_code      = cur_mis ? TRAP_LDST_MISALIGN : trap_code_mem;
  assign cur_shadow    = shadow[cur_idx];
  assign cur_ld        = ext_load(cur_shadow, cur_off, funct3_mem);
  assign cur_wdata     = store_word(rs2_data_mem, funct3_mem);
  assign cur_strb      = mem_write_mem ? lane_strb(funct3_mem, cur_off) : '0;
  assign exp_ren       = mem_read_mem && !cur_trap;
  assign exp_we        = mem_write_mem && !cur_trap;

  always_comb begin
    case (res_src_mem)
      RES_MEM: exp_res = cur_ld;
      RES_PC4: exp_res = pc_plus4_mem;
      RES_TGT: exp_res = jb_target_mem;
      default: exp_res = alu_result_mem;
    endcase
  end

  assign wb_item = {reg_write_wb, res_src_wb, rd_wb, alu_result_wb, ld_data_wb,
                    pc_plus4_wb, jb_target_wb, trap_wb, trap_code_wb};

  // Combinational SRAM whose strobed lanes land at the edge
  assign dmem_rdata = mem[dmem_raddr[7:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (dmem_wstrb[i]) begin
          mem[dmem_waddr[7:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  // Expected queue, shadow memory and first-transfer flag
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      seen_xfer <= 1'b0;
    end else begin
      if (m_valid && m_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (s_valid && s_ready) begin
        exp_q.push_back({reg_write_mem && !cur_trap, res_src_mem, rd_mem, alu_result_mem,
                         cur_ld, pc_plus4_mem, jb_target_mem, cur_trap, cur_code});
        seen_xfer <= 1'b1;
      end
      // A held store rewrites the same lanes, so no handshake is needed here
      if (mem_write_mem && !cur_trap) begin
        for (int i = 0; i < BYTE_LANES; i++) begin
          if (cur_strb[i]) begin
            shadow[cur_idx][8*i +: 8] <= cur_wdata[8*i +: 8];
          end
        end
      end
    end
    head_item <= (exp_q.size() > 0) ? exp_q[0] : '0;
    q_count   <= exp_q.size();
  end

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    errors++;
    $display("ERROR: %s got %h expected %h", name, got, exp);
  endtask

  task automatic item_mismatch(input logic [ITEM_W-1:0] got, input logic [ITEM_W-1:0] exp);
    errors++;
    $display("ERROR: writeback {reg_write_wb..trap_code_wb} got %h expected %h", got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("check failed: %s", msg);
  endtask

  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_xfer |-> !m_valid)
    else report_failure("m_valid rose before any item was accepted");

  a_trap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    cur_trap |-> !dmem_ren && !dmem_we)
    else report_failure("data memory enabled for a trapping access");

  a_load_ren: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_ren == exp_ren)
    else report_mismatch("dmem_ren", 32'($sampled(dmem_ren)), 32'($sampled(exp_ren)));

  a_store_we: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we == exp_we)
    else report_mismatch("dmem_we", 32'($sampled(dmem_we)), 32'($sampled(exp_we)));

  a_raddr: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> dmem_raddr == cur_word_addr)
    else report_mismatch("dmem_raddr", $sampled(dmem_raddr), $sampled(cur_word_addr));

  a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> dmem_waddr == cur_word_addr)
    else report_mismatch("dmem_waddr", $sampled(dmem_waddr), $sampled(cur_word_addr));

  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    mem_write_mem && !cur_trap |-> dmem_wdata == cur_wdata)
    else report_mismatch("dmem_wdata", $sampled(dmem_wdata), $sampled(cur_wdata));

  a_wstrb: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> dmem_wstrb == cur_strb)
    else report_mismatch("dmem_wstrb", 32'($sampled(dmem_wstrb)), 32'($sampled(cur_strb)));

  // Merged store words show up again on every read
  a_mem_word: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> dmem_rdata == cur_shadow)
    else report_mismatch("dmem_rdata", $sampled(dmem_rdata), $sampled(cur_shadow));

  a_fwd_result: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> result_mem == exp_res)
    else report_mismatch("result_mem", $sampled(result_mem), $sampled(exp_res));

  a_fwd_load: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid |-> load_data_mem == cur_ld)
    else report_mismatch("load_data_mem", $sampled(load_data_mem), $sampled(cur_ld));

  a_wb_extra: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && m_ready |-> q_count > 0)
    else report_failure("writeback delivered an item that was never accepted");

  a_wb_item: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && m_ready && q_count > 0 |-> wb_item == head_item)
    else item_mismatch($sampled(wb_item), $sampled(head_item));

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(wb_item))
    else report_failure("writeback outputs moved while stalled");

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Writeback only stalls an item it already holds
  initial begin
    m_ready = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      m_ready = (m_valid === 1'b1) ? ($urandom_range(2) != 0) : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic clear_inputs();
    s_valid        = 1'b0;
    reg_write_mem  = 1'b0;
    mem_read_mem   = 1'b0;
    mem_write_mem  = 1'b0;
    res_src_mem    = RES_ALU;
    rd_mem         = '0;
    funct3_mem     = F3_W;
    alu_result_mem = '0;
    rs2_data_mem   = '0;
    pc_plus4_mem   = '0;
    jb_target_mem  = '0;
    trap_mem       = 1'b0;
    trap_code_mem  = TRAP_NONE;
  endtask

  // Kinds 0 stores, 1 loads, 2 misaligned, 3 mixed
  task automatic issue_item(input int kind);
    int         op;
    funct3_t    f3;
    logic [1:0] off;
    word_t      addr;
    // Occasional bubble between items
    if ($urandom_range(3) == 0) begin
      #DRIVE_DLY;
      clear_inputs();
      @(posedge clk);
    end
    case (kind)
      0:       op = 2;
      1:       op = 1;
      2:       op = 1 + int'($urandom_range(1));
      default: op = int'($urandom_range(2));
    endcase
    f3   = f3_codes[$urandom_range(4)];
    off  = 2'($urandom_range(3));
    addr = $urandom;
    if (kind == 2) begin
      // Bytes cannot misalign, so widen them to a word
      if (f3[1:0] == 2'b00) begin
        f3 = F3_W;
      end
      if (f3[1:0] == 2'b01) begin
        off[0] = 1'b1;
      end else if (off == 2'b00) begin
        off = 2'($urandom_range(3, 1));
      end
    end else if (kind != 3) begin
      // Round the offset down to the access size
      if (f3[1:0] == 2'b01) begin
        off[0] = 1'b0;
      end
      if (f3[1:0] == 2'b10) begin
        off = 2'b00;
      end
    end
    #DRIVE_DLY;
    s_valid        = 1'b1;
    mem_read_mem   = (op == 1);
    mem_write_mem  = (op == 2);
    funct3_mem     = f3;
    alu_result_mem = {addr[31:2], off};
    res_src_mem    = (op == 1) ? RES_MEM : res_src_t'($urandom_range(3));
    reg_write_mem  = 1'($urandom_range(1));
    rd_mem         = 5'($urandom);
    rs2_data_mem   = $urandom;
    pc_plus4_mem   = $urandom;
    jb_target_mem  = $urandom;
    trap_mem       = (kind == 3) && ($urandom_range(7) == 0);
    if (trap_mem) begin
      trap_code_mem = ($urandom_range(1) == 0) ? TRAP_ILLEGAL : TRAP_FETCH_MISALIGN;
    end else begin
      trap_code_mem = TRAP_NONE;
    end
    // Held until the stage takes it
    do @(posedge clk); while (!s_ready);
    total_items++;
  endtask

  task automatic report_test(input string name, input int items, input int err_mark);
    $display("test %-10s %0d items, %0d errors, %s", name, items, errors - err_mark,
             (errors == err_mark) ? "ok" : "bad");
  endtask

  initial begin
    int err_mark;
    void'($urandom(32'he625b0aa));
    rst_n = 1'b0;
    clear_inputs();
    for (int i = 0; i < 64; i++) begin
      mem[i]    = 32'h9e3779b9 * 32'(i + 1);
      shadow[i] = 32'h9e3779b9 * 32'(i + 1);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    err_mark = errors;
    repeat (4) @(posedge clk);
    report_test("reset", 0, err_mark);
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_mark = errors;
      for (int n = 0; n < ITEMS_PER_TEST; n++) begin
        issue_item(t);
      end
      report_test(test_names[t], ITEMS_PER_TEST, err_mark);
    end
    // Let writeback drain what is still queued
    #DRIVE_DLY;
    clear_inputs();
    while (q_count != 0 || m_valid) @(posedge clk);
    @(posedge clk);
    $display("summary: %0d tests, %0d items, %0d errors", NUM_TESTS + 1, total_items, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_stage.f
common/mem_stage_pkg.sv
design/store_align.sv
design/load_extend.sv
design/ldst_misalign_check.sv
design/mem_wb_reg.sv
design/mem_stage.sv
bench/mem_stage_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_stage_tb
FILELIST  := mem_stage.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the outcome, not the simulator's exit status
run: compile
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
